/* ex_stage.f */
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_mult.sv
ex_result.sv
ex_stage.sv
ex_stage_chk.sv
tb_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -Wno-fatal --top-module tb_ex_stage -f ex_stage.f \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_ex_stage > sim.log 2>&1
cat sim.log

grep -qx "TB PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* tb_ex_stage.sv */
/*
  Testbench for ex_stage at the default widths with checks by immediate assertions
  Inputs change on the rising edge and outputs are sampled on the falling edge
*/
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage
  import ex_pkg::*;
();

  logic        clk;
  logic        rst_n;
  ex_op_u      ex_op_i;
  logic [31:0] operand_a_i;
  logic [31:0] operand_b_i;
  logic [31:0] operand_c_i;
  logic        csr_access_i;
  logic [31:0] csr_rdata_i;
  logic        lsu_en_i;
  logic [31:0] lsu_rdata_i;
  logic        lsu_ready_ex_i;
  logic        lsu_err_i;
  logic        branch_in_ex_i;
  logic        regfile_alu_we_i;
  logic [5:0]  regfile_alu_waddr_i;
  logic        regfile_we_i;
  logic [5:0]  regfile_waddr_i;
  logic        wb_ready_i;
  logic        regfile_alu_we_fw_o;
  logic [5:0]  regfile_alu_waddr_fw_o;
  logic [31:0] regfile_alu_wdata_fw_o;
  logic        regfile_we_wb_o;
  logic [5:0]  regfile_waddr_wb_o;
  logic [31:0] regfile_wdata_wb_o;
  logic [31:0] jump_target_o;
  logic        branch_decision_o;
  logic        mult_multicycle_o;
  logic        ex_ready_o;
  logic        ex_valid_o;

  int          errors;
  int          checks;
  int          tests;
  logic [31:0] rng_state;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ex_stage #(.DATA_W(32), .ADDR_W(6)) ex_stage_inst (.*);

  //////////////////////////////////////////////////
  // Stimulus helpers and reference model
  //////////////////////////////////////////////////

  // xorshift32 step
  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic ex_op_u alu_word(alu_op_e op);
    ex_op_u w;
    w.alu.unit = UNIT_ALU;
    w.alu.op   = op;
    w.alu.rsvd = 2'b00;
    return w;
  endfunction

  function automatic ex_op_u mult_word(mult_op_e op);
    ex_op_u w;
    w.mult.unit = UNIT_MULT;
    w.mult.op   = op;
    w.mult.rsvd = 4'b0000;
    return w;
  endfunction

  // Branch and set-less-than rules
  function automatic logic model_cmp(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] model_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << sh;
      ALU_SRL: return a >> sh;
      ALU_SRA: return $signed(a) >>> sh;
      default: return {31'b0, model_cmp(op, a, b)};
    endcase
  endfunction

  // 64-bit product of the extended operands modulo 2**64
  function automatic logic [31:0] model_mul(mult_op_e op, logic [31:0] a, logic [31:0] b);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] p;
    ax = (op == MULT_MULH || op == MULT_MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
    bx = (op == MULT_MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    p  = ax * bx;
    return (op == MULT_MUL) ? p[31:0] : p[63:32];
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    assert (exp === act) else begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic apply(ex_op_u op, logic [31:0] a, logic [31:0] b, logic [31:0] c);
    @(posedge clk);
    ex_op_i     <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    operand_c_i <= c;
  endtask

  task automatic set_idle();
    @(posedge clk);
    ex_op_i        <= '0;
    csr_access_i   <= 1'b0;
    lsu_en_i       <= 1'b0;
    regfile_we_i   <= 1'b0;
    lsu_err_i      <= 1'b0;
    branch_in_ex_i <= 1'b0;
    wb_ready_i     <= 1'b1;
  endtask

  // Counts stall cycles; hi_ok drops if a stall is not a multiplier phase 1
  task automatic wait_valid(string name, output int stalls, output bit hi_ok);
    bit got;
    got    = 1'b0;
    stalls = 0;
    hi_ok  = 1'b1;
    for (int n = 0; n < 8; n++) begin
      @(negedge clk);
      if (ex_valid_o) begin
        got = 1'b1;
        break;
      end
      stalls++;
      if (!(mult_multicycle_o && !ex_ready_o)) hi_ok = 1'b0;
    end
    if (!got) begin
      $display("Timeout in %s, ex_valid_o did not rise within 8 cycles", name);
      errors++;
    end
  endtask

  task automatic end_test(string name, int err_before);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - err_before);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int          e0;
    int          stalls;
    bit          hi_ok;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;

    errors              = 0;
    checks              = 0;
    tests               = 0;
    rng_state           = 32'h6d82e9a4;
    rst_n               = 1'b0;
    ex_op_i             = '0;
    operand_a_i         = '0;
    operand_b_i         = '0;
    operand_c_i         = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Every ALU operator gives its result and forwarding address in the same cycle
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      a = next_rand();
      b = next_rand();
      c = next_rand();
      apply(alu_word(alu_op_e'(i[3:0])), a, b, 32'h0);
      regfile_alu_we_i    <= i[0];
      regfile_alu_waddr_i <= c[5:0];
      wait_valid($sformatf("alu op %0d", i), stalls, hi_ok);
      check_val($sformatf("alu op %0d", i), model_alu(alu_op_e'(i[3:0]), a, b),
                regfile_alu_wdata_fw_o);
      check_bit($sformatf("alu op %0d no stall", i), 1'b1, stalls == 0);
      check_bit($sformatf("alu op %0d fw we", i), i[0], regfile_alu_we_fw_o);
      check_val($sformatf("alu op %0d fw addr", i), 32'(c[5:0]),
                32'(regfile_alu_waddr_fw_o));
    end
    end_test("alu", e0);

    // Comparisons with a second round on equal operands
    e0 = errors;
    for (int r = 0; r < 2; r++) begin
      for (int i = 8; i < 16; i++) begin
        a = next_rand();
        b = (r == 1) ? a : next_rand();
        c = next_rand();
        apply(alu_word(alu_op_e'(i[3:0])), a, b, c);
        branch_in_ex_i <= 1'b1;
        wait_valid($sformatf("branch op %0d", i), stalls, hi_ok);
        check_bit($sformatf("branch op %0d", i), model_cmp(alu_op_e'(i[3:0]), a, b),
                  branch_decision_o);
        check_val("jump target", c, jump_target_o);
      end
    end
    set_idle();
    end_test("branch", e0);

    // MUL takes one cycle and the high variants one stall
    e0 = errors;
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < 4; i++) begin
        a = next_rand();
        b = next_rand();
        apply(mult_word(mult_op_e'(i[1:0])), a, b, 32'h0);
        wait_valid($sformatf("mult op %0d", i), stalls, hi_ok);
        check_val($sformatf("mult op %0d", i), model_mul(mult_op_e'(i[1:0]), a, b),
                  regfile_alu_wdata_fw_o);
        check_val($sformatf("mult op %0d stalls", i), (i == 0) ? 32'd0 : 32'd1, stalls);
        check_bit($sformatf("mult op %0d phase", i), 1'b1, hi_ok);
      end
    end
    set_idle();
    end_test("mult", e0);

    // CSR data wins over both units and the product wins over the ALU
    e0 = errors;
    a = next_rand();
    b = next_rand();
    d = next_rand();
    apply(alu_word(ALU_ADD), a, b, 32'h0);
    csr_access_i <= 1'b1;
    csr_rdata_i  <= d;
    wait_valid("prio csr alu", stalls, hi_ok);
    check_val("prio csr alu", d, regfile_alu_wdata_fw_o);
    apply(mult_word(MULT_MULHU), a, b, 32'h0);
    wait_valid("prio csr mult", stalls, hi_ok);
    check_val("prio csr mult", d, regfile_alu_wdata_fw_o);
    apply(mult_word(MULT_MUL), a, b, 32'h0);
    csr_access_i <= 1'b0;
    wait_valid("prio mult", stalls, hi_ok);
    check_val("prio mult", model_mul(MULT_MUL, a, b), regfile_alu_wdata_fw_o);
    set_idle();
    end_test("priority", e0);

    // Load/store write one cycle after the valid and then a squashed one
    e0 = errors;
    c = next_rand();
    d = next_rand();
    apply('0, 32'h0, 32'h0, 32'h0);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= c[5:0];
    wait_valid("lsu write", stalls, hi_ok);
    @(posedge clk);
    lsu_en_i     <= 1'b0;
    regfile_we_i <= 1'b0;
    lsu_rdata_i  <= d;
    @(negedge clk);
    check_bit("lsu we", 1'b1, regfile_we_wb_o);
    check_val("lsu addr", 32'(c[5:0]), 32'(regfile_waddr_wb_o));
    check_val("lsu data", d, regfile_wdata_wb_o);
    apply('0, 32'h0, 32'h0, 32'h0);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    lsu_err_i       <= 1'b1;
    regfile_waddr_i <= ~c[5:0];
    wait_valid("lsu error", stalls, hi_ok);
    set_idle();
    @(negedge clk);
    check_bit("lsu error we", 1'b0, regfile_we_wb_o);
    end_test("lsu", e0);

    // Write-back stall holds the port while a branch still releases EX
    e0 = errors;
    a = next_rand();
    b = next_rand();
    c = next_rand();
    apply('0, 32'h0, 32'h0, 32'h0);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= c[5:0];
    wait_valid("bp write", stalls, hi_ok);
    apply(alu_word(ALU_ADD), a, b, 32'h0);
    lsu_en_i     <= 1'b0;
    regfile_we_i <= 1'b0;
    wb_ready_i   <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_bit("bp valid", 1'b0, ex_valid_o);
      check_bit("bp ready", 1'b0, ex_ready_o);
      check_bit("bp we", 1'b1, regfile_we_wb_o);
      check_val("bp addr", 32'(c[5:0]), 32'(regfile_waddr_wb_o));
    end
    @(posedge clk);
    branch_in_ex_i <= 1'b1;
    @(negedge clk);
    check_bit("bp branch ready", 1'b1, ex_ready_o);
    check_bit("bp branch valid", 1'b0, ex_valid_o);
    @(posedge clk);
    branch_in_ex_i <= 1'b0;
    wb_ready_i     <= 1'b1;
    wait_valid("bp release", stalls, hi_ok);
    check_val("bp release", model_alu(ALU_ADD, a, b), regfile_alu_wdata_fw_o);
    set_idle();
    end_test("backpressure", e0);

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ex_stage_chk.sv */
/*
  Protocol assertions on the load/store write port and the stage valid
  Bound into every ex_result instance
*/
`timescale 1ns/10ps
`default_nettype none

module ex_stage_chk #(
  parameter int ADDR_W = 6
) (
  input logic              clk,
  input logic              rst_n,
  input logic              ex_valid_o,
  input logic              regfile_we_i,
  input logic [ADDR_W-1:0] regfile_waddr_i,
  input logic              lsu_err_i,
  input logic              wb_ready_i,
  input logic              regfile_we_wb_o,
  input logic [ADDR_W-1:0] regfile_waddr_wb_o
);

  // Clean write lands on the port one cycle later with its address
  wb_write_follows: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o && regfile_we_i && !lsu_err_i |=>
      regfile_we_wb_o && (regfile_waddr_wb_o == $past(regfile_waddr_i)))
    else $error("load/store write did not follow a valid write");

  // No valid while write-back is stalled
  no_valid_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |-> !ex_valid_o)
    else $error("ex_valid_o high while wb_ready_i low");

  wb_port_holds: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(regfile_we_wb_o) && $stable(regfile_waddr_wb_o))
    else $error("load/store port changed under back-pressure");

endmodule

bind ex_result ex_stage_chk #(.ADDR_W(ADDR_W)) ex_stage_chk_inst (
  .clk                (clk),
  .rst_n              (rst_n),
  .ex_valid_o         (ex_valid_o),
  .regfile_we_i       (regfile_we_i),
  .regfile_waddr_i    (regfile_waddr_i),
  .lsu_err_i          (lsu_err_i),
  .wb_ready_i         (wb_ready_i),
  .regfile_we_wb_o    (regfile_we_wb_o),
  .regfile_waddr_wb_o (regfile_waddr_wb_o)
);

`default_nettype wire

/* ex_stage.sv */
/*
  Execute stage top, wires decode, ALU, multiplier and result logic
  Jump target is operand c as given; branch decision comes from the ALU
*/
`timescale 1ns/10ps
`default_nettype none

module ex_stage
  import ex_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEF,
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_op_u            ex_op_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  input  logic [DATA_W-1:0] operand_c_i,
  input  logic              csr_access_i,
  input  logic [DATA_W-1:0] csr_rdata_i,
  input  logic              lsu_en_i,
  input  logic [DATA_W-1:0] lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  logic [ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  logic [ADDR_W-1:0] regfile_waddr_i,
  input  logic              wb_ready_i,

  output logic              regfile_alu_we_fw_o,
  output logic [ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [DATA_W-1:0] regfile_alu_wdata_fw_o,
  output logic              regfile_we_wb_o,
  output logic [ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [DATA_W-1:0] regfile_wdata_wb_o,
  output logic [DATA_W-1:0] jump_target_o,
  output logic              branch_decision_o,
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic              alu_en;
  alu_op_e           alu_op;
  logic              mult_en;
  mult_op_e          mult_op;
  logic [DATA_W-1:0] alu_result;
  logic              cmp_result;
  logic [DATA_W-1:0] mult_result;
  logic              mult_ready;

  assign branch_decision_o = cmp_result;
  assign jump_target_o     = operand_c_i;

  ex_decode ex_decode_inst (
    .ex_op_i   (ex_op_i),
    .alu_en_o  (alu_en),
    .alu_op_o  (alu_op),
    .mult_en_o (mult_en),
    .mult_op_o (mult_op)
  );

  ex_alu #(.DATA_W(DATA_W)) ex_alu_inst (
    .alu_en_i     (alu_en),
    .alu_op_i     (alu_op),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (cmp_result)
  );

  // Stage ready tells the multiplier when its second cycle retires
  ex_mult #(.DATA_W(DATA_W)) ex_mult_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_en_i    (mult_en),
    .mult_op_i    (mult_op),
    .op_a_i       (operand_a_i),
    .op_b_i       (operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_result #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) ex_result_inst (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en),
    .mult_en_i              (mult_en),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .mult_ready_i           (mult_ready),
    .csr_access_i           (csr_access_i),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_en_i               (lsu_en_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

/* ex_result.sv */
/*
  Forwarding port mux, registered load/store write port and stage handshake
  Inputs must stay stable while ex_ready_o is low
*/
`timescale 1ns/10ps
`default_nettype none

module ex_result
  import ex_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEF,
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic [DATA_W-1:0] alu_result_i,
  input  logic [DATA_W-1:0] mult_result_i,
  input  logic              mult_ready_i,
  input  logic              csr_access_i,
  input  logic [DATA_W-1:0] csr_rdata_i,
  input  logic              lsu_en_i,
  input  logic [DATA_W-1:0] lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  logic [ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  logic [ADDR_W-1:0] regfile_waddr_i,
  input  logic              wb_ready_i,

  output logic              regfile_alu_we_fw_o,
  output logic [ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [DATA_W-1:0] regfile_alu_wdata_fw_o,
  output logic              regfile_we_wb_o,
  output logic [ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [DATA_W-1:0] regfile_wdata_wb_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic              lsu_we_q;
  logic [ADDR_W-1:0] lsu_waddr_q;
  logic              lsu_write;
  logic              units_ready;

  // Forwarding port, later assignment wins: CSR over MULT over ALU
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i) regfile_alu_wdata_fw_o = alu_result_i;
    if (mult_en_i) regfile_alu_wdata_fw_o = mult_result_i;
    if (csr_access_i) regfile_alu_wdata_fw_o = csr_rdata_i;
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  //////////////////////////////////////////////////
  // Load/store write port register
  //////////////////////////////////////////////////

  // Bus error squashes the write
  assign lsu_write = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_o) begin
      lsu_we_q <= lsu_write;
      if (lsu_write) lsu_waddr_q <= regfile_waddr_i;
    end else if (wb_ready_i) begin
      // WB is free but nothing arrived, drain the old write
      lsu_we_q <= 1'b0;
    end
  end

  // Data comes straight from the LSU in the write-back cycle
  assign regfile_we_wb_o    = lsu_we_q;
  assign regfile_waddr_wb_o = lsu_waddr_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX, so they never wait on write-back
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid flows downstream only, no dependence on ex_ready_o
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

`default_nettype wire

/* ex_mult.sv */
/*
  Multiplier, low product in one cycle, high product in two
  Only one high multiply can be in flight; the phase flag clears on ex_ready_i
*/
`timescale 1ns/10ps
`default_nettype none

module ex_mult
  import ex_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mult_en_i,
  input  mult_op_e          mult_op_i,
  input  logic [DATA_W-1:0] op_a_i,
  input  logic [DATA_W-1:0] op_b_i,
  input  logic              ex_ready_i,

  output logic [DATA_W-1:0] result_o,
  output logic              ready_o,
  output logic              multicycle_o
);

  // One extra bit per operand covers signed and unsigned alike
  localparam int PROD_W = 2 * DATA_W + 2;

  logic                     sign_a;
  logic                     sign_b;
  logic                     is_high;
  logic                     first_cyc;
  logic                     hi_phase_q;
  logic signed [DATA_W:0]   a_ext;
  logic signed [DATA_W:0]   b_ext;
  logic signed [PROD_W-1:0] prod;
  logic [DATA_W-1:0]        prod_hi_q;

  //////////////////////////////////////////////////
  // Operand extension and product
  //////////////////////////////////////////////////

  assign sign_a = (mult_op_i == MULT_MULH) || (mult_op_i == MULT_MULHSU);
  assign sign_b = (mult_op_i == MULT_MULH);

  assign a_ext = {sign_a & op_a_i[DATA_W-1], op_a_i};
  assign b_ext = {sign_b & op_b_i[DATA_W-1], op_b_i};
  assign prod  = a_ext * b_ext;

  // First cycle of a high multiply
  assign is_high   = mult_op_i != MULT_MUL;
  assign first_cyc = mult_en_i & is_high & ~hi_phase_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hi_phase_q <= 1'b0;
    end else if (first_cyc) begin
      hi_phase_q <= 1'b1;
    end else if (hi_phase_q && ex_ready_i) begin
      // Stage advanced with the upper half
      hi_phase_q <= 1'b0;
    end
  end

  // Upper half captured in cycle 1
  always_ff @(posedge clk) begin
    if (first_cyc) begin
      prod_hi_q <= prod[2*DATA_W-1:DATA_W];
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign result_o     = hi_phase_q ? prod_hi_q : prod[DATA_W-1:0];
  assign ready_o      = ~first_cyc;
  assign multicycle_o = first_cyc;

endmodule

`default_nettype wire

/* ex_alu.sv */
/*
  Purely combinational integer ALU and branch comparator
  Shift amount is the low clog2(DATA_W) bits of b; DATA_W must be at least 8
*/
`timescale 1ns/10ps
`default_nettype none

module ex_alu
  import ex_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic              alu_en_i,
  input  alu_op_e           alu_op_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,

  output logic [DATA_W-1:0] result_o,
  output logic              cmp_result_o
);

  localparam int SHAMT_W = $clog2(DATA_W);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_s;
  logic               lt_u;
  logic               eq;
  logic               cmp;
  logic signed [DATA_W-1:0] sra_res;

  assign shamt   = operand_b_i[SHAMT_W-1:0];
  assign sra_res = $signed(operand_a_i) >>> shamt;

  //////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////

  assign lt_s = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u = operand_a_i < operand_b_i;
  assign eq   = operand_a_i == operand_b_i;

  always_comb begin
    cmp = 1'b0;
    case (alu_op_i)
      ALU_SLT, ALU_LT:   cmp = lt_s;
      ALU_SLTU, ALU_LTU: cmp = lt_u;
      ALU_EQ:            cmp = eq;
      ALU_NE:            cmp = ~eq;
      ALU_GE:            cmp = ~lt_s;
      ALU_GEU:           cmp = ~lt_u;
      default:           cmp = 1'b0;
    endcase
  end

  // Branch decision only when the ALU owns the instruction
  assign cmp_result_o = alu_en_i & cmp;

  //////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      ALU_SRA: result_o = sra_res;
      // Comparisons give 0 or 1
      default: result_o = {{(DATA_W-1){1'b0}}, cmp};
    endcase
  end

endmodule

`default_nettype wire

/* ex_decode.sv */
/*
  Splits the operation word into unit enables and operators
  Enables are exclusive; an unknown unit code enables nothing
*/
`timescale 1ns/10ps
`default_nettype none

module ex_decode
  import ex_pkg::*;
(
  input  ex_op_u   ex_op_i,

  output logic     alu_en_o,
  output alu_op_e  alu_op_o,
  output logic     mult_en_o,
  output mult_op_e mult_op_o
);

  ex_unit_e unit;

  // Unit field is at the same bits in both views
  assign unit = ex_op_i.alu.unit;

  //////////////////////////////////////////////////
  // Unit select and operator extraction
  //////////////////////////////////////////////////

  always_comb begin
    // Idle operators when the unit is not selected
    alu_en_o  = 1'b0;
    alu_op_o  = ALU_ADD;
    mult_en_o = 1'b0;
    mult_op_o = MULT_MUL;

    case (unit)
      UNIT_ALU: begin
        alu_en_o = 1'b1;
        // Word read as ALU fields
        alu_op_o = ex_op_i.alu.op;
      end
      UNIT_MULT: begin
        mult_en_o = 1'b1;
        // Word read as multiplier fields
        mult_op_o = ex_op_i.mult.op;
      end
      default: begin
        // None or unknown code, nothing enabled
        alu_en_o  = 1'b0;
        mult_en_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* ex_pkg.sv */
/*
  Shared codes and types for the execute stage
  The unit field sits in bits 7:6 of the operation word in both views
*/
`default_nettype none

package ex_pkg;

  // Default widths, the top level may override them
  localparam int DATA_W_DEF = 32;
  localparam int ADDR_W_DEF = 6;

  // Unit select, code 2'b11 is unknown and decodes as none
  typedef enum logic [1:0] {
    UNIT_NONE = 2'b00,
    UNIT_ALU  = 2'b01,
    UNIT_MULT = 2'b10
  } ex_unit_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // MUL gives the low half, the others the high half
  typedef enum logic [1:0] {
    MULT_MUL, MULT_MULH, MULT_MULHSU, MULT_MULHU
  } mult_op_e;

  typedef struct packed {
    ex_unit_e   unit;
    alu_op_e    op;
    logic [1:0] rsvd;
  } alu_fields_t;

  typedef struct packed {
    ex_unit_e   unit;
    mult_op_e   op;
    logic [3:0] rsvd;
  } mult_fields_t;

  // One 8-bit operation word, read through either view
  typedef union packed {
    alu_fields_t  alu;
    mult_fields_t mult;
  } ex_op_u;

endpackage

`default_nettype wire
